//--- rtl/sum_kernel_consts.svh
//////////////////////////////
// Widths and credit counts for the sum compute unit
// Included by the package and by modules that size from these values
//////////////////////////////

`ifndef SUM_KERNEL_CONSTS_SVH
`define SUM_KERNEL_CONSTS_SVH

// Datapath widths
`define EDGE_WEIGHT_BITS 16
`define SUM_BITS         32
`define VERTEX_ID_BITS   16
`define DEGREE_BITS      8
`define TOTAL_BITS       32

// Producer side edge credits at reset
`define EDGE_CREDITS     4

// Result credits held by the unit at reset
`define RESULT_CREDITS   2

`endif

//--- rtl/sum_kernel_pkg.sv
//////////////////////////////
// Shared types of the sum compute unit
// Referenced by scoped name from the RTL and the testbench
//////////////////////////////

`default_nettype none

`include "sum_kernel_consts.svh"

package sum_kernel_pkg;

	// One weight off the edge stream
	typedef logic [`EDGE_WEIGHT_BITS-1:0] edge_weight_t;

	// Accumulated sum, wraps on overflow
	typedef logic [`SUM_BITS-1:0] sum_t;

	// Vertex identifier carried from job to result
	typedef logic [`VERTEX_ID_BITS-1:0] vertex_id_t;

	// Degree of a job, also the per-job edge count
	typedef logic [`DEGREE_BITS-1:0] degree_t;

	// Edges consumed since reset
	typedef logic [`TOTAL_BITS-1:0] total_t;

	//////////////////////////////
	// Job state machine
	//////////////////////////////
	typedef enum logic [1:0] {
		IDLE        = 2'd0,
		ACCUM       = 2'd1,
		WAIT_CREDIT = 2'd2,
		EMIT        = 2'd3
	} job_state_e;

endpackage

`default_nettype wire

//--- rtl/accum_ctrl_if.sv
//////////////////////////////
// Handshake between the job state machine and the accumulator
// State machine takes control, accumulator takes datapath
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface accum_ctrl_if;

	// Arm pulse and edge budget from the state machine
	logic                    start;
	sum_kernel_pkg::degree_t degree;

	// Completion level, held until the next start
	logic                    done;
	sum_kernel_pkg::sum_t    sum;
	sum_kernel_pkg::degree_t count;

	// State machine side
	modport control (
		output start, degree,
		input  done, sum, count
	);

	// Accumulator side
	modport datapath (
		input  start, degree,
		output done, sum, count
	);

endinterface

`default_nettype wire

//--- rtl/result_credit_counter.sv
//////////////////////////////
// Result credit pool, one credit spent per emitted result
// Consumer credit pulses refill it up to CREDITS
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sum_kernel_consts.svh"

module result_credit_counter #(
	parameter int CREDITS = `RESULT_CREDITS
) (
	input  logic clock,
	input  logic rstn,
	input  logic credit_give,
	input  logic credit_spend,
	output logic have_credit
);

	localparam int CNT_BITS = $clog2(CREDITS + 1);

	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] count_next;

	// Give and spend together leave the count alone
	always_comb begin
		count_next = count;
		if (credit_give && !credit_spend)
			count_next = count + 1'b1;
		else if (!credit_give && credit_spend)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count <= CNT_BITS'(CREDITS);
		end else begin
			count <= count_next;
		end
	end

	assign have_credit = (count != '0);

	// Spend only comes from the state machine after it saw a credit
	a_no_spend_at_zero: assert property (@(posedge clock) disable iff (!rstn)
		credit_spend |-> (count != '0))
		else $error("result credit spent with an empty pool");

	// Consumer must not return more than it was given
	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		count <= CNT_BITS'(CREDITS))
		else $error("result credit pool above its limit");

endmodule

`default_nettype wire

//--- rtl/edge_sum_accumulator.sv
//////////////////////////////
// Edge latch then add pipeline for one vertex job at a time
// Returns an edge credit per accepted edge, keeps the edge total
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sum_kernel_consts.svh"

module edge_sum_accumulator (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         edge_valid,
	input  sum_kernel_pkg::edge_weight_t edge_weight,
	output logic                         edge_credit,
	output sum_kernel_pkg::total_t       edge_total,
	accum_ctrl_if.datapath               ctl
);

	localparam int CRED_BITS = $clog2(`EDGE_CREDITS + 1);

	logic                         lat_valid;
	sum_kernel_pkg::edge_weight_t lat_weight;
	logic                         armed;
	logic                         done_q;
	sum_kernel_pkg::sum_t         sum_q;
	sum_kernel_pkg::degree_t      count_q;
	logic                         last_edge;
	logic [CRED_BITS-1:0]         producer_credits;

	//////////////////////////////
	// Stage one, edge latch
	//////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lat_valid <= 1'b0;
		end else begin
			lat_valid <= edge_valid;
		end
	end

	// Weight zeroed when no edge arrives
	always_ff @(posedge clock) begin
		lat_weight <= edge_valid ? edge_weight : '0;
	end

	// One credit back per latched edge
	assign edge_credit = lat_valid;

	//////////////////////////////
	// Stage two, sum and count
	//////////////////////////////
	assign last_edge = (sum_kernel_pkg::degree_t'(count_q + 1'b1) == ctl.degree);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			armed   <= 1'b0;
			done_q  <= 1'b0;
			sum_q   <= '0;
			count_q <= '0;
		end else if (ctl.start) begin
			// Zero degree finishes right away
			armed   <= (ctl.degree != '0);
			done_q  <= (ctl.degree == '0);
			sum_q   <= '0;
			count_q <= '0;
		end else if (armed && lat_valid) begin
			sum_q   <= sum_q + sum_kernel_pkg::sum_t'(lat_weight);
			count_q <= count_q + 1'b1;
			if (last_edge) begin
				armed  <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	// Running total of every edge that reached stage two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_total <= '0;
		end else if (lat_valid) begin
			edge_total <= edge_total + 1'b1;
		end
	end

	assign ctl.done  = done_q;
	assign ctl.sum   = sum_q;
	assign ctl.count = count_q;

	// Mirror of the producer's credit count
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			producer_credits <= CRED_BITS'(`EDGE_CREDITS);
		end else begin
			case ({edge_valid, edge_credit})
				2'b10: producer_credits <= producer_credits - 1'b1;
				2'b01: producer_credits <= producer_credits + 1'b1;
				default: producer_credits <= producer_credits;
			endcase
		end
	end

	a_edge_needs_credit: assert property (@(posedge clock) disable iff (!rstn)
		edge_valid |-> (producer_credits != '0))
		else $error("edge sent without an edge credit");

	// Edges only after the job was taken and before its budget is used
	a_edge_when_armed: assert property (@(posedge clock) disable iff (!rstn)
		edge_valid |-> (armed || ctl.start))
		else $error("edge accepted while the accumulator is not armed");

	// Stale count is allowed only in the start cycle
	a_count_le_degree: assert property (@(posedge clock) disable iff (!rstn)
		!ctl.start |-> (count_q <= ctl.degree))
		else $error("edge count above the job degree");

endmodule

`default_nettype wire

//--- rtl/vertex_job_control.sv
//////////////////////////////
// Job state machine of the sum unit
// Takes a job, arms the accumulator, emits one result per job
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vertex_job_control (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       job_valid,
	input  sum_kernel_pkg::vertex_id_t job_vertex,
	input  sum_kernel_pkg::degree_t    job_degree,
	output logic                       job_ready,
	input  logic                       have_credit,
	output logic                       credit_spend,
	output logic                       result_valid,
	output sum_kernel_pkg::vertex_id_t result_vertex,
	accum_ctrl_if.control              ctl
);

	sum_kernel_pkg::job_state_e state;
	sum_kernel_pkg::job_state_e state_next;
	sum_kernel_pkg::vertex_id_t vertex_q;
	sum_kernel_pkg::degree_t    degree_q;
	logic                       start_q;
	logic                       job_take;

	assign job_ready = (state == sum_kernel_pkg::IDLE);
	assign job_take  = job_valid && job_ready;

	//////////////////////////////
	// Next state
	//////////////////////////////
	always_comb begin
		state_next = state;
		case (state)
			sum_kernel_pkg::IDLE: begin
				if (job_take)
					state_next = sum_kernel_pkg::ACCUM;
			end
			sum_kernel_pkg::ACCUM: begin
				// Done is stale while start is still high
				if (ctl.done && !start_q)
					state_next = sum_kernel_pkg::WAIT_CREDIT;
			end
			sum_kernel_pkg::WAIT_CREDIT: begin
				if (have_credit)
					state_next = sum_kernel_pkg::EMIT;
			end
			sum_kernel_pkg::EMIT: begin
				state_next = sum_kernel_pkg::IDLE;
			end
			default: state_next = sum_kernel_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state   <= sum_kernel_pkg::IDLE;
			start_q <= 1'b0;
		end else begin
			state   <= state_next;
			// Start follows the job take by one cycle
			start_q <= job_take;
		end
	end

	// Job fields held for the whole job
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_q <= '0;
			degree_q <= '0;
		end else if (job_take) begin
			vertex_q <= job_vertex;
			degree_q <= job_degree;
		end
	end

	assign ctl.start  = start_q;
	assign ctl.degree = degree_q;

	// Result and credit spend share the EMIT cycle
	assign result_valid  = (state == sum_kernel_pkg::EMIT);
	assign credit_spend  = result_valid;
	assign result_vertex = vertex_q;

	a_result_has_credit: assert property (@(posedge clock) disable iff (!rstn)
		result_valid |-> have_credit)
		else $error("result emitted without a result credit");

	// Busy until a result has gone out
	a_ready_after_result: assert property (@(posedge clock) disable iff (!rstn)
		(!job_ready && !result_valid) |=> !job_ready)
		else $error("job port ready before the result was emitted");

endmodule

`default_nettype wire

//--- rtl/sum_kernel_unit.sv
//////////////////////////////
// Sum compute unit top, job in, edges summed, result out
// Credit flow control on the edge and result streams
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sum_kernel_unit (
	input  logic                         clock,
	input  logic                         rstn,
	// Job port
	input  logic                         job_valid,
	input  sum_kernel_pkg::vertex_id_t   job_vertex,
	input  sum_kernel_pkg::degree_t      job_degree,
	output logic                         job_ready,
	// Edge port
	input  logic                         edge_valid,
	input  sum_kernel_pkg::edge_weight_t edge_weight,
	output logic                         edge_credit,
	// Result port
	output logic                         result_valid,
	output sum_kernel_pkg::vertex_id_t   result_vertex,
	output sum_kernel_pkg::sum_t         result_sum,
	output sum_kernel_pkg::degree_t      result_count,
	input  logic                         result_credit,
	// Running total
	output sum_kernel_pkg::total_t       edge_total
);

	logic have_credit;
	logic credit_spend;

	accum_ctrl_if u_accum_ctrl_if ();

	vertex_job_control u_vertex_job_control (
		.clock         (clock),
		.rstn          (rstn),
		.job_valid     (job_valid),
		.job_vertex    (job_vertex),
		.job_degree    (job_degree),
		.job_ready     (job_ready),
		.have_credit   (have_credit),
		.credit_spend  (credit_spend),
		.result_valid  (result_valid),
		.result_vertex (result_vertex),
		.ctl           (u_accum_ctrl_if.control)
	);

	edge_sum_accumulator u_edge_sum_accumulator (
		.clock       (clock),
		.rstn        (rstn),
		.edge_valid  (edge_valid),
		.edge_weight (edge_weight),
		.edge_credit (edge_credit),
		.edge_total  (edge_total),
		.ctl         (u_accum_ctrl_if.datapath)
	);

	result_credit_counter u_result_credit_counter (
		.clock        (clock),
		.rstn         (rstn),
		.credit_give  (result_credit),
		.credit_spend (credit_spend),
		.have_credit  (have_credit)
	);

	// Sum and count stay held while the result waits
	assign result_sum   = u_accum_ctrl_if.sum;
	assign result_count = u_accum_ctrl_if.count;

endmodule

`default_nettype wire

//--- dv/tb_sum_kernel_unit.sv
//////////////////////////////
// Directed testbench of the sum compute unit
// Credit-limited edge producer, result scoreboard, cycle timeout
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sum_kernel_consts.svh"

module tb_sum_kernel_unit;

	// Longest test is six jobs of up to 255 edges, about 1700 cycles in all
	localparam int MAX_CYCLES = 4000;

	logic                         clock;
	logic                         rstn;
	logic                         job_valid;
	sum_kernel_pkg::vertex_id_t   job_vertex;
	sum_kernel_pkg::degree_t      job_degree;
	logic                         job_ready;
	logic                         edge_valid;
	sum_kernel_pkg::edge_weight_t edge_weight;
	logic                         edge_credit;
	logic                         result_valid;
	sum_kernel_pkg::vertex_id_t   result_vertex;
	sum_kernel_pkg::sum_t         result_sum;
	sum_kernel_pkg::degree_t      result_count;
	logic                         result_credit;
	sum_kernel_pkg::total_t       edge_total;

	// Producer and consumer state
	int  credits = `EDGE_CREDITS;
	int  credits_owed = 0;
	bit  hold_credits = 1'b0;
	int  edges_sent = 0;
	int  results_seen = 0;
	int  checks = 0;
	int  errors = 0;
	int  cycles = 0;

	sum_kernel_pkg::edge_weight_t edge_q[$];
	sum_kernel_pkg::edge_weight_t next_weights[$];
	sum_kernel_pkg::vertex_id_t   exp_vertex[$];
	sum_kernel_pkg::sum_t         exp_sum[$];
	sum_kernel_pkg::degree_t      exp_count[$];

	sum_kernel_unit u_sum_kernel_unit (
		.clock         (clock),
		.rstn          (rstn),
		.job_valid     (job_valid),
		.job_vertex    (job_vertex),
		.job_degree    (job_degree),
		.job_ready     (job_ready),
		.edge_valid    (edge_valid),
		.edge_weight   (edge_weight),
		.edge_credit   (edge_credit),
		.result_valid  (result_valid),
		.result_vertex (result_vertex),
		.result_sum    (result_sum),
		.result_count  (result_count),
		.result_credit (result_credit),
		.edge_total    (edge_total)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("FAILED at %0t ns: %s", $time, msg);
		end
	endtask

	task automatic print_summary;
		$display("checks %0d, errors %0d, results %0d, edges %0d",
			checks, errors, results_seen, edges_sent);
	endtask

	//////////////////////////////
	// Edge producer
	//////////////////////////////
	always @(negedge clock) begin
		if (rstn) begin
			edge_valid  = 1'b0;
			edge_weight = '0;
			// Send only on a credit held before this cycle's return
			if (credits > 0 && edge_q.size() > 0) begin
				edge_valid  = 1'b1;
				edge_weight = edge_q.pop_front();
				credits--;
				edges_sent++;
			end
			if (edge_credit) begin
				credits++;
				check(credits <= `EDGE_CREDITS, "edge credit returned beyond the limit");
			end
		end
	end

	//////////////////////////////
	// Result monitor and credit return
	//////////////////////////////
	always @(negedge clock) begin
		if (rstn) begin
			result_credit = 1'b0;
			if (!hold_credits && credits_owed > 0) begin
				result_credit = 1'b1;
				credits_owed--;
			end
			if (result_valid) begin
				results_seen++;
				credits_owed++;
				if (exp_vertex.size() == 0) begin
					errors++;
					$display("Unexpected result at %0t ns with no job outstanding", $time);
				end else begin
					check(result_vertex == exp_vertex[0], $sformatf(
						"vertex %0h, expected %0h", result_vertex, exp_vertex[0]));
					check(result_sum == exp_sum[0], $sformatf(
						"sum %0h, expected %0h", result_sum, exp_sum[0]));
					check(result_count == exp_count[0], $sformatf(
						"count %0d, expected %0d", result_count, exp_count[0]));
					void'(exp_vertex.pop_front());
					void'(exp_sum.pop_front());
					void'(exp_count.pop_front());
				end
			end
		end
	end

	// Runaway guard
	always @(posedge clock) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			print_summary();
			$display("=== FAIL ===");
			$finish;
		end
	end

	//////////////////////////////
	// Job and drain helpers
	//////////////////////////////

	// Job made of next_weights, expected sum wraps at 32 bits
	task automatic send_job(input sum_kernel_pkg::vertex_id_t vertex);
		sum_kernel_pkg::sum_t expect_sum;
		expect_sum = '0;
		foreach (next_weights[i])
			expect_sum = expect_sum + sum_kernel_pkg::sum_t'(next_weights[i]);
		exp_vertex.push_back(vertex);
		exp_sum.push_back(expect_sum);
		exp_count.push_back(sum_kernel_pkg::degree_t'(next_weights.size()));
		@(negedge clock);
		while (!job_ready)
			@(negedge clock);
		job_valid  = 1'b1;
		job_vertex = vertex;
		job_degree = sum_kernel_pkg::degree_t'(next_weights.size());
		@(negedge clock);
		job_valid = 1'b0;
		// Job taken, its edges may go out now
		foreach (next_weights[i])
			edge_q.push_back(next_weights[i]);
		next_weights.delete();
	endtask

	// Wait for all edges and results, and for the result credits to go back
	task automatic drain;
		@(negedge clock);
		while (edge_q.size() != 0 || exp_vertex.size() != 0 || credits_owed != 0)
			@(negedge clock);
		@(negedge clock);
	endtask

	function automatic sum_kernel_pkg::edge_weight_t near_max_weight();
		return 16'hFFFF - sum_kernel_pkg::edge_weight_t'($urandom % 16);
	endfunction

	//////////////////////////////
	// Tests
	//////////////////////////////
	task automatic test_after_reset;
		check(job_ready == 1'b1, "job_ready low after reset");
		check(result_valid == 1'b0, "result_valid high after reset");
		check(edge_credit == 1'b0, "edge_credit high after reset");
		check(edge_total == '0, $sformatf("edge_total %0d after reset", edge_total));
	endtask

	task automatic test_single_job;
		sum_kernel_pkg::total_t total_before;
		total_before = edge_total;
		next_weights = '{16'd10, 16'd250, 16'd1000, 16'd40000, 16'd7};
		send_job(16'h0101);
		drain();
		check(edge_total == total_before + 5, $sformatf(
			"edge_total %0d, expected %0d", edge_total, total_before + 5));
	endtask

	task automatic test_degree_zero;
		send_job(16'h0202);
		drain();
	endtask

	// Jobs queued without waiting for results in between
	task automatic test_back_to_back;
		int degrees[6] = '{3, 7, 1, 9, 4, 6};
		foreach (degrees[j]) begin
			for (int i = 0; i < degrees[j]; i++)
				next_weights.push_back(sum_kernel_pkg::edge_weight_t'(17 * i + 300 * j + 1));
			send_job(sum_kernel_pkg::vertex_id_t'(16'h0300 + j));
		end
		drain();
		check(credits == `EDGE_CREDITS, $sformatf("edge credits %0d after drain", credits));
	endtask

	task automatic test_result_backpressure;
		int base;
		base = results_seen;
		hold_credits = 1'b1;
		for (int j = 0; j <= `RESULT_CREDITS; j++) begin
			for (int i = 0; i < 5; i++)
				next_weights.push_back(sum_kernel_pkg::edge_weight_t'(1000 * j + i));
			send_job(sum_kernel_pkg::vertex_id_t'(16'h0400 + j));
		end
		// Last job is stuck in WAIT_CREDIT
		repeat (40) begin
			@(negedge clock);
			check(!job_ready, "job_ready high while a result waits for credit");
			check(!result_valid, "result emitted with result credits withheld");
		end
		check(results_seen - base == `RESULT_CREDITS, $sformatf(
			"%0d results with credits withheld", results_seen - base));
		hold_credits = 1'b0;
		next_weights = '{16'd5, 16'd6};
		send_job(16'h04FF);
		drain();
		check(results_seen - base == `RESULT_CREDITS + 2, $sformatf(
			"%0d results after credit return", results_seen - base));
	endtask

	task automatic test_random_weights;
		int degree;
		for (int j = 0; j < 6; j++) begin
			degree = 200 + ($urandom % 56);
			for (int i = 0; i < degree; i++)
				next_weights.push_back(near_max_weight());
			send_job(sum_kernel_pkg::vertex_id_t'($urandom));
		end
		drain();
		check(edge_total == sum_kernel_pkg::total_t'(edges_sent), $sformatf(
			"edge_total %0d, edges sent %0d", edge_total, edges_sent));
	endtask

	initial begin
		void'($urandom(32'h464d92fd));
		rstn          = 1'b0;
		job_valid     = 1'b0;
		job_vertex    = '0;
		job_degree    = '0;
		edge_valid    = 1'b0;
		edge_weight   = '0;
		result_credit = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		test_after_reset();
		test_single_job();
		test_degree_zero();
		test_back_to_back();
		test_result_backpressure();
		test_random_weights();
		print_summary();
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/sum_kernel_pkg.sv
rtl/accum_ctrl_if.sv
rtl/result_credit_counter.sv
rtl/edge_sum_accumulator.sv
rtl/vertex_job_control.sv
rtl/sum_kernel_unit.sv
dv/tb_sum_kernel_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the sum unit testbench with Verilator
# A failing run is detected by the fail message in sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sum_kernel_unit -f list.f \
	--Mdir obj_dir -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "=== FAIL ===" sim.log \
	&& { echo "simulation reported failure, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
